//--- Bender.yml
package:
  name: mips_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/mips_pkg.sv
      - src/mem_req_if.sv
      - src/pc_counter.sv
      - src/reg_file.sv
      - src/decode_unit.sv
      - src/execute_stage.sv
      - src/data_port_ctrl.sv
      - src/mips_pipe.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_mips_pipe.sv

//--- mips_pipe.f
+incdir+src
src/mips_pkg.sv
src/mem_req_if.sv
src/pc_counter.sv
src/reg_file.sv
src/decode_unit.sv
src/execute_stage.sv
src/data_port_ctrl.sv
src/mips_pipe.sv
testbench/tb_mips_pipe.sv

//--- src/data_port_ctrl.sv
`timescale 1ns/1ps

module data_port_ctrl (
    input  logic               clk,
    input  logic               arst_n_i,
    mem_req_if.dst             req,
    output logic               data_en_o,
    output logic [3:0]         data_wen_o,
    output mips_pkg::word_t    data_addr_o,
    output mips_pkg::word_t    data_wdata_o,
    input  mips_pkg::word_t    data_rdata_i,
    input  logic               data_ok_i,
    output logic               busy_o,
    output logic               wb_valid_o,
    output mips_pkg::reg_idx_t wb_dest_o,
    output mips_pkg::word_t    wb_data_o,
    output mips_pkg::word_t    wb_pc_o
);
    import mips_pkg::*;

    port_state_t state_q;
    port_state_t state_d;
    logic        valid_q;
    logic        wb_en_q;
    logic        is_load_q;
    logic        is_store_q;
    logic        accept;
    word_t       addr_q;
    word_t       wdata_q;
    word_t       result_q;
    word_t       pc_q;
    reg_idx_t    dest_q;

    assign req.ready = (state_q != ACCESS);
    assign accept    = req.valid & req.ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                if (accept && (req.is_load || req.is_store)) begin
                    state_d = ACCESS;
                end else begin
                    state_d = IDLE;
                end
            end
            ACCESS: begin
                if (data_ok_i) begin
                    state_d = DONE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            valid_q    <= 1'b0;
            wb_en_q    <= 1'b0;
            is_load_q  <= 1'b0;
            is_store_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (req.ready) begin
                valid_q    <= req.valid;
                wb_en_q    <= req.wb_en;
                is_load_q  <= req.is_load;
                is_store_q <= req.is_store;
            end
        end
    end

    // Load data replaces the address once the bus answers
    always_ff @(posedge clk) begin
        if (req.ready) begin
            addr_q   <= req.addr;
            wdata_q  <= req.wdata;
            dest_q   <= req.dest;
            pc_q     <= req.pc;
            result_q <= req.result;
        end else if (data_ok_i && is_load_q) begin
            result_q <= data_rdata_i;
        end
    end

    assign data_en_o    = (state_q == ACCESS);
    assign data_wen_o   = {4{data_en_o & is_store_q}};
    assign data_addr_o  = addr_q;
    assign data_wdata_o = wdata_q;
    assign busy_o       = (state_q == ACCESS);

    // Also the memory-stage forwarding source
    assign wb_valid_o = valid_q & wb_en_q & (state_q != ACCESS);
    assign wb_dest_o  = dest_q;
    assign wb_data_o  = result_q;
    assign wb_pc_o    = pc_q;

    addr_stable_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        data_en_o && !data_ok_i |=> data_en_o && $stable(data_addr_o));

    // Execute keeps an untaken request unchanged
    req_hold_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        req.valid && !req.ready |=> req.valid && $stable(req.addr));

endmodule

//--- src/decode_unit.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module decode_unit (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               hold_i,
    input  logic               inst_valid_i,
    input  mips_pkg::inst_t    inst_i,
    input  mips_pkg::word_t    pc_i,
    output mips_pkg::reg_idx_t rs_o,
    output mips_pkg::reg_idx_t rt_o,
    input  mips_pkg::word_t    rs_data_i,
    input  mips_pkg::word_t    rt_data_i,
    input  logic               ex_fwd_en_i,
    input  mips_pkg::reg_idx_t ex_fwd_dest_i,
    input  mips_pkg::word_t    ex_fwd_data_i,
    input  logic               mem_fwd_en_i,
    input  mips_pkg::reg_idx_t mem_fwd_dest_i,
    input  mips_pkg::word_t    mem_fwd_data_i,
    input  mips_pkg::reg_idx_t ex_load_dest_i,
    input  logic               ex_is_load_i,
    output logic               stall_o,
    output logic               op_valid_o,
    output mips_pkg::alu_op_t  alu_op_o,
    output mips_pkg::word_t    src_a_o,
    output mips_pkg::word_t    src_b_o,
    output mips_pkg::word_t    store_data_o,
    output mips_pkg::reg_idx_t dest_o,
    output logic               wb_en_o,
    output logic               is_load_o,
    output logic               is_store_o,
    output mips_pkg::word_t    pc_o
);
    import mips_pkg::*;

    logic  valid_q;
    inst_t inst_q;
    word_t pc_q;
    word_t rs_val;
    word_t rt_val;
    word_t imm_sext;
    logic  known;
    logic  uses_rt;
    logic  ld;
    logic  st;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q <= inst_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            inst_q <= inst_i;
            pc_q   <= pc_i;
        end
    end

    // Youngest producer wins, so execute is checked first
    function automatic word_t fwd_pick(reg_idx_t idx, word_t rf_val,
                                       logic ex_en, reg_idx_t ex_dest, word_t ex_data,
                                       logic mem_en, reg_idx_t mem_dest, word_t mem_data);
        if (idx == '0) begin
            return '0;
        end
        if (ex_en && (ex_dest == idx)) begin
            return ex_data;
        end
        if (mem_en && (mem_dest == idx)) begin
            return mem_data;
        end
        return rf_val;
    endfunction

    assign rs_o     = inst_q[25:21];
    assign rt_o     = inst_q[20:16];
    assign imm_sext = {{16{inst_q[15]}}, inst_q[15:0]};
    assign rs_val   = fwd_pick(rs_o, rs_data_i, ex_fwd_en_i, ex_fwd_dest_i, ex_fwd_data_i,
                               mem_fwd_en_i, mem_fwd_dest_i, mem_fwd_data_i);
    assign rt_val   = fwd_pick(rt_o, rt_data_i, ex_fwd_en_i, ex_fwd_dest_i, ex_fwd_data_i,
                               mem_fwd_en_i, mem_fwd_dest_i, mem_fwd_data_i);
    assign pc_o     = pc_q;

    always_comb begin
        alu_op_o     = ALU_ADD;
        src_a_o      = rs_val;
        src_b_o      = imm_sext;
        store_data_o = rt_val;
        dest_o       = rt_o;
        known        = 1'b1;
        uses_rt      = 1'b0;
        ld           = 1'b0;
        st           = 1'b0;
        case (inst_q[31:26])
            `OP_SPECIAL: begin
                src_b_o = rt_val;
                dest_o  = inst_q[15:11];
                uses_rt = 1'b1;
                case (inst_q[5:0])
                    `FN_ADDU: alu_op_o = ALU_ADD;
                    `FN_SUBU: alu_op_o = ALU_SUB;
                    `FN_AND:  alu_op_o = ALU_AND;
                    `FN_OR:   alu_op_o = ALU_OR;
                    default:  known    = 1'b0;
                endcase
            end
            `OP_ADDIU: alu_op_o = ALU_ADD;
            `OP_LUI:   alu_op_o = ALU_LUI;
            `OP_LW:    ld       = 1'b1;
            `OP_SW: begin
                st      = 1'b1;
                uses_rt = 1'b1;
            end
            // Anything else retires without effect
            default: known = 1'b0;
        endcase
    end

    assign op_valid_o = valid_q;
    assign wb_en_o    = valid_q & known & ~st;
    assign is_load_o  = valid_q & ld;
    assign is_store_o = valid_q & st;

    // Load result not ready until the memory stage
    assign stall_o = valid_q & ex_is_load_i & (ex_load_dest_i != '0) &
                     ((ex_load_dest_i == rs_o) | (uses_rt & (ex_load_dest_i == rt_o)));

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               hold_i,
    input  logic               bubble_i,
    input  logic               op_valid_i,
    input  mips_pkg::alu_op_t  alu_op_i,
    input  mips_pkg::word_t    src_a_i,
    input  mips_pkg::word_t    src_b_i,
    input  mips_pkg::word_t    store_data_i,
    input  mips_pkg::reg_idx_t dest_i,
    input  logic               wb_en_i,
    input  logic               is_load_i,
    input  logic               is_store_i,
    input  mips_pkg::word_t    pc_i,
    mem_req_if.src             req
);
    import mips_pkg::*;

    logic     valid_q;
    logic     wb_en_q;
    logic     is_load_q;
    logic     is_store_q;
    alu_op_t  alu_op_q;
    word_t    a_q;
    word_t    b_q;
    word_t    store_q;
    word_t    pc_q;
    reg_idx_t dest_q;
    word_t    alu_res;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q    <= 1'b0;
            wb_en_q    <= 1'b0;
            is_load_q  <= 1'b0;
            is_store_q <= 1'b0;
        end else if (!hold_i) begin
            valid_q    <= op_valid_i & ~bubble_i;
            wb_en_q    <= wb_en_i & ~bubble_i;
            is_load_q  <= is_load_i & ~bubble_i;
            is_store_q <= is_store_i & ~bubble_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold_i) begin
            alu_op_q <= alu_op_i;
            a_q      <= src_a_i;
            b_q      <= src_b_i;
            store_q  <= store_data_i;
            dest_q   <= dest_i;
            pc_q     <= pc_i;
        end
    end

    // Loads and stores use the add path for base plus offset
    always_comb begin
        case (alu_op_q)
            ALU_ADD: alu_res = a_q + b_q;
            ALU_SUB: alu_res = a_q - b_q;
            ALU_AND: alu_res = a_q & b_q;
            ALU_OR:  alu_res = a_q | b_q;
            ALU_LUI: alu_res = {b_q[15:0], 16'h0000};
            default: alu_res = '0;
        endcase
    end

    assign req.valid    = valid_q;
    assign req.is_load  = is_load_q;
    assign req.is_store = is_store_q;
    assign req.addr     = alu_res;
    assign req.wdata    = store_q;
    assign req.dest     = dest_q;
    assign req.wb_en    = wb_en_q;
    assign req.result   = alu_res;
    assign req.pc       = pc_q;

endmodule

//--- src/mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
    import mips_pkg::*;

    logic     valid;
    logic     ready;
    logic     is_load;
    logic     is_store;
    word_t    addr;
    word_t    wdata;
    reg_idx_t dest;
    logic     wb_en;
    word_t    result;
    word_t    pc;

    // Request moves when valid and ready meet on a clock edge
    modport src (
        output valid, is_load, is_store, addr, wdata, dest, wb_en, result, pc,
        input  ready
    );

    modport dst (
        input  valid, is_load, is_store, addr, wdata, dest, wb_en, result, pc,
        output ready
    );

endinterface

//--- src/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Primary opcodes, bits 31:26
`define OP_SPECIAL 6'b000000
`define OP_ADDIU   6'b001001
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

// Function codes for OP_SPECIAL, bits 5:0
`define FN_ADDU    6'b100001
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101

// First fetch address after reset
`define RESET_PC   32'h0000_0000

`define REG_COUNT  32

`endif

//--- src/mips_pipe.sv
`timescale 1ns/1ps

module mips_pipe (
    input  logic               clk,
    input  logic               arst_n_i,
    output logic               inst_en_o,
    output mips_pkg::word_t    inst_addr_o,
    input  mips_pkg::inst_t    inst_data_i,
    input  logic               inst_ok_i,
    output logic               data_en_o,
    output logic [3:0]         data_wen_o,
    output mips_pkg::word_t    data_addr_o,
    output mips_pkg::word_t    data_wdata_o,
    input  mips_pkg::word_t    data_rdata_i,
    input  logic               data_ok_i,
    output mips_pkg::word_t    wb_pc_o,
    output logic [3:0]         wb_rf_wen_o,
    output mips_pkg::reg_idx_t wb_rf_wnum_o,
    output mips_pkg::word_t    wb_rf_wdata_o
);
    import mips_pkg::*;

    logic     run_q;
    logic     busy;
    logic     ld_stall;
    logic     fetch_ok;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    rs_data;
    word_t    rt_data;
    logic     id_valid;
    alu_op_t  id_alu_op;
    word_t    id_src_a;
    word_t    id_src_b;
    word_t    id_store_data;
    reg_idx_t id_dest;
    logic     id_wb_en;
    logic     id_is_load;
    logic     id_is_store;
    word_t    id_pc;
    logic     mem_valid;
    reg_idx_t mem_dest;
    word_t    mem_data;
    word_t    mem_pc;
    logic     rf_wen;
    logic     wb_wen_q;
    reg_idx_t wb_num_q;
    word_t    wb_data_q;
    word_t    wb_pc_q;

    mem_req_if mreq ();

    // Keeps fetch quiet until the first cycle out of reset
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            run_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
        end
    end

    assign inst_en_o = run_q & ~busy & ~ld_stall;
    assign fetch_ok  = inst_en_o & inst_ok_i;

    pc_counter u_pc (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .advance_i (fetch_ok),
        .pc_o      (inst_addr_o)
    );

    decode_unit u_decode (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .hold_i         (busy | ld_stall),
        .inst_valid_i   (fetch_ok),
        .inst_i         (inst_data_i),
        .pc_i           (inst_addr_o),
        .rs_o           (rs),
        .rt_o           (rt),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .ex_fwd_en_i    (mreq.valid & mreq.wb_en & ~mreq.is_load),
        .ex_fwd_dest_i  (mreq.dest),
        .ex_fwd_data_i  (mreq.result),
        .mem_fwd_en_i   (mem_valid),
        .mem_fwd_dest_i (mem_dest),
        .mem_fwd_data_i (mem_data),
        .ex_load_dest_i (mreq.dest),
        .ex_is_load_i   (mreq.valid & mreq.is_load),
        .stall_o        (ld_stall),
        .op_valid_o     (id_valid),
        .alu_op_o       (id_alu_op),
        .src_a_o        (id_src_a),
        .src_b_o        (id_src_b),
        .store_data_o   (id_store_data),
        .dest_o         (id_dest),
        .wb_en_o        (id_wb_en),
        .is_load_o      (id_is_load),
        .is_store_o     (id_is_store),
        .pc_o           (id_pc)
    );

    execute_stage u_execute (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .hold_i       (busy),
        .bubble_i     (ld_stall),
        .op_valid_i   (id_valid),
        .alu_op_i     (id_alu_op),
        .src_a_i      (id_src_a),
        .src_b_i      (id_src_b),
        .store_data_i (id_store_data),
        .dest_i       (id_dest),
        .wb_en_i      (id_wb_en),
        .is_load_i    (id_is_load),
        .is_store_i   (id_is_store),
        .pc_i         (id_pc),
        .req          (mreq)
    );

    data_port_ctrl u_dport (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req          (mreq),
        .data_en_o    (data_en_o),
        .data_wen_o   (data_wen_o),
        .data_addr_o  (data_addr_o),
        .data_wdata_o (data_wdata_o),
        .data_rdata_i (data_rdata_i),
        .data_ok_i    (data_ok_i),
        .busy_o       (busy),
        .wb_valid_o   (mem_valid),
        .wb_dest_o    (mem_dest),
        .wb_data_o    (mem_data),
        .wb_pc_o      (mem_pc)
    );

    // Register file takes the result as it leaves memory
    assign rf_wen = mem_valid & (mem_dest != '0);

    reg_file u_rf (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .raddr_a_i (rs),
        .raddr_b_i (rt),
        .rdata_a_o (rs_data),
        .rdata_b_o (rt_data),
        .wen_i     (rf_wen),
        .waddr_i   (mem_dest),
        .wdata_i   (mem_data)
    );

    // Memory/writeback register, drives the debug port
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_wen_q <= 1'b0;
        end else begin
            wb_wen_q <= rf_wen;
        end
    end

    always_ff @(posedge clk) begin
        wb_num_q  <= mem_dest;
        wb_data_q <= mem_data;
        wb_pc_q   <= mem_pc;
    end

    assign wb_pc_o       = wb_pc_q;
    assign wb_rf_wen_o   = {4{wb_wen_q}};
    assign wb_rf_wnum_o  = wb_num_q;
    assign wb_rf_wdata_o = wb_data_q;

endmodule

//--- src/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_LUI
    } alu_op_t;

    // Data-port controller
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } port_state_t;

endpackage

//--- src/pc_counter.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module pc_counter (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            advance_i,
    output mips_pkg::word_t pc_o
);
    import mips_pkg::*;

    word_t pc_q;

    // One word per accepted fetch, sequential only
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (advance_i) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module reg_file (
    input  logic               clk,
    input  logic               arst_n_i,
    input  mips_pkg::reg_idx_t raddr_a_i,
    input  mips_pkg::reg_idx_t raddr_b_i,
    output mips_pkg::word_t    rdata_a_o,
    output mips_pkg::word_t    rdata_b_o,
    input  logic               wen_i,
    input  mips_pkg::reg_idx_t waddr_i,
    input  mips_pkg::word_t    wdata_i
);
    import mips_pkg::*;

    word_t regs_q [`REG_COUNT];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // r0 reads as zero whatever the array holds
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    no_r0_write_a: assert property (@(posedge clk) disable iff (!arst_n_i)
        wen_i |-> (waddr_i != '0));

endmodule

//--- testbench/tb_mips_pipe.sv
`timescale 1ns/1ps
`include "mips_consts.svh"

module tb_mips_pipe;
    import mips_pkg::*;

    logic        clk = 1'b0;
    logic        arst_n_i;
    logic        inst_en_o;
    word_t       inst_addr_o;
    inst_t       inst_data_i;
    logic        inst_ok_i;
    logic        data_en_o;
    logic [3:0]  data_wen_o;
    word_t       data_addr_o;
    word_t       data_wdata_o;
    word_t       data_rdata_i;
    logic        data_ok_i;
    word_t       wb_pc_o;
    logic [3:0]  wb_rf_wen_o;
    reg_idx_t    wb_rf_wnum_o;
    word_t       wb_rf_wdata_o;

    inst_t       imem [256];
    word_t       dmem [64];
    word_t       exp_wr_pc [$];
    reg_idx_t    exp_wr_num [$];
    word_t       exp_wr_val [$];
    word_t       exp_st_addr [$];
    word_t       exp_st_data [$];
    word_t       fetch_pc;

    // Bus state seen at the falling edge and acted on at the next rising edge
    logic        fetch_seen;
    word_t       iaddr_s;
    word_t       inext;
    int          iwait;
    logic        d_en_s;
    logic        d_ok_s;
    logic [3:0]  d_wen_s;
    word_t       d_addr_s;
    word_t       d_wdata_s;
    int          d_wait;

    always #2 clk = ~clk;

    mips_pipe UUT (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .inst_en_o     (inst_en_o),
        .inst_addr_o   (inst_addr_o),
        .inst_data_i   (inst_data_i),
        .inst_ok_i     (inst_ok_i),
        .data_en_o     (data_en_o),
        .data_wen_o    (data_wen_o),
        .data_addr_o   (data_addr_o),
        .data_wdata_o  (data_wdata_o),
        .data_rdata_i  (data_rdata_i),
        .data_ok_i     (data_ok_i),
        .wb_pc_o       (wb_pc_o),
        .wb_rf_wen_o   (wb_rf_wen_o),
        .wb_rf_wnum_o  (wb_rf_wnum_o),
        .wb_rf_wdata_o (wb_rf_wdata_o)
    );

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(string what, word_t exp, word_t got);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s expected %h, got %h", $time, what, exp,
                got));
        end
    endtask

    task automatic check_reg(string what, reg_idx_t exp, reg_idx_t got);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s expected r%0d, got r%0d", $time, what, exp,
                got));
        end
    endtask

    task automatic check_strobe(string what, logic [3:0] exp, logic [3:0] got);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0t ns: %s expected %b, got %b", $time, what, exp,
                got));
        end
    endtask

    function automatic word_t fill_word(int idx);
        return 32'h5a00_00c3 ^ (word_t'(idx) * 32'h0103_0407);
    endfunction

    // Registers r0..r7 only, so dependencies are frequent
    task automatic build_program();
        reg_idx_t    rs;
        reg_idx_t    rt;
        reg_idx_t    rd;
        reg_idx_t    last_dest;
        logic [15:0] imm;
        logic [15:0] off;
        int          kind;
        last_dest = '0;
        for (int w = 0; w < 256; w++) begin
            imem[w] = {6'b111111, 16'h0000, w[7:0], 2'b00};
        end
        for (int m = 0; m < 64; m++) begin
            dmem[m] = fill_word(m);
        end
        for (int i = 0; i < 64; i++) begin
            kind = $urandom % 9;
            rs   = ($urandom % 2 != 0) ? last_dest : reg_idx_t'($urandom % 8);
            rt   = reg_idx_t'($urandom % 8);
            rd   = reg_idx_t'($urandom % 8);
            imm  = 16'($urandom);
            off  = {8'h00, 6'($urandom % 64), 2'b00};
            case (kind)
                0: imem[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_ADDU};
                1: imem[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_SUBU};
                2: imem[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_AND};
                3: imem[i] = {`OP_SPECIAL, rs, rt, rd, 5'd0, `FN_OR};
                4: imem[i] = {`OP_ADDIU, rs, rt, imm};
                5: imem[i] = {`OP_LUI, 5'd0, rt, imm};
                6: imem[i] = {`OP_LW, 5'd0, rt, off};
                7: imem[i] = {`OP_SW, 5'd0, last_dest, off};
                default: imem[i] = {6'b111111, 26'($urandom)};
            endcase
            if (kind < 4) begin
                last_dest = rd;
            end else if (kind < 7) begin
                last_dest = rt;
            end
        end
    endtask

    // In-order ISA model filling the expected write and store queues
    task automatic run_model();
        word_t    regs [32];
        word_t    mem [64];
        inst_t    inst;
        word_t    a;
        word_t    b;
        word_t    sext;
        word_t    addr;
        word_t    res;
        reg_idx_t dest;
        logic     wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        for (int m = 0; m < 64; m++) begin
            mem[m] = dmem[m];
        end
        for (int i = 0; i < 64; i++) begin
            inst = imem[i];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            addr = a + sext;
            dest = inst[20:16];
            res  = '0;
            wr   = 1'b1;
            case (inst[31:26])
                `OP_SPECIAL: begin
                    dest = inst[15:11];
                    case (inst[5:0])
                        `FN_ADDU: res = a + b;
                        `FN_SUBU: res = a - b;
                        `FN_AND:  res = a & b;
                        `FN_OR:   res = a | b;
                        default:  wr  = 1'b0;
                    endcase
                end
                `OP_ADDIU: res = a + sext;
                `OP_LUI:   res = {inst[15:0], 16'h0000};
                `OP_LW:    res = mem[addr[7:2]];
                `OP_SW: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && (dest != '0)) begin
                regs[dest] = res;
                exp_wr_pc.push_back(word_t'(i * 4));
                exp_wr_num.push_back(dest);
                exp_wr_val.push_back(res);
            end
        end
    endtask

    task automatic wait_for_retire();
        int cycles;
        cycles = 0;
        while ((exp_wr_pc.size() != 0) || (exp_st_addr.size() != 0)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 4000) begin
                abort_run($sformatf("Timeout: %0d register writes and %0d stores never arrived",
                    exp_wr_pc.size(), exp_st_addr.size()));
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        fetch_seen = inst_en_o && inst_ok_i;
        iaddr_s    = inst_addr_o;
        d_en_s     = data_en_o;
        d_ok_s     = data_ok_i;
        d_wen_s    = data_wen_o;
        d_addr_s   = data_addr_o;
        d_wdata_s  = data_wdata_o;
        if (!arst_n_i) begin
            if ((inst_en_o !== 1'b0) || (data_en_o !== 1'b0) || (wb_rf_wen_o !== 4'h0)) begin
                abort_run("A bus enable or the writeback enable was active during reset");
            end
        end else begin
            if (fetch_seen) begin
                check_word("fetch address", fetch_pc, inst_addr_o);
                fetch_pc = fetch_pc + 32'd4;
            end
            if (data_en_o && data_ok_i && (data_wen_o != 4'h0)) begin
                if (exp_st_addr.size() == 0) begin
                    abort_run("A store completed that the program does not contain");
                end
                check_strobe("store byte enables", 4'hf, data_wen_o);
                check_word("store address", exp_st_addr.pop_front(), data_addr_o);
                check_word("store data", exp_st_data.pop_front(), data_wdata_o);
            end
            if (wb_rf_wen_o != 4'h0) begin
                if (wb_rf_wnum_o == '0) begin
                    abort_run("The writeback port reported a write to r0");
                end
                if (exp_wr_pc.size() == 0) begin
                    abort_run("A register write appeared that the program does not contain");
                end
                check_strobe("writeback enable", 4'hf, wb_rf_wen_o);
                check_word("writeback pc", exp_wr_pc.pop_front(), wb_pc_o);
                check_reg("writeback register", exp_wr_num.pop_front(), wb_rf_wnum_o);
                check_word("writeback data", exp_wr_val.pop_front(), wb_rf_wdata_o);
            end
        end
    end

    // Instruction and data responders with 0 to 3 wait cycles
    always @(posedge clk) begin
        if (fetch_seen) begin
            inext = iaddr_s + 32'd4;
            iwait = $urandom % 4;
        end else begin
            inext = iaddr_s;
            if (iwait != 0) begin
                iwait = iwait - 1;
            end
        end
        inst_ok_i   <= (iwait == 0);
        inst_data_i <= imem[inext[9:2]];

        if (d_en_s && d_ok_s) begin
            if (d_wen_s != 4'h0) begin
                dmem[d_addr_s[7:2]] = d_wdata_s;
            end
            data_ok_i <= 1'b0;
            d_wait = $urandom % 4;
        end else if (d_en_s) begin
            if (d_wait == 0) begin
                data_ok_i    <= 1'b1;
                data_rdata_i <= dmem[d_addr_s[7:2]];
            end else begin
                d_wait = d_wait - 1;
            end
        end else begin
            data_ok_i <= 1'b0;
        end
    end

    initial begin
        void'($urandom(32'h202d));
        arst_n_i     = 1'b0;
        inst_data_i  = '0;
        inst_ok_i    = 1'b0;
        data_rdata_i = '0;
        data_ok_i    = 1'b0;
        fetch_pc     = `RESET_PC;
        fetch_seen   = 1'b0;
        iaddr_s      = '0;
        iwait        = 0;
        d_en_s       = 1'b0;
        d_ok_s       = 1'b0;
        d_wait       = 0;
        build_program();
        run_model();
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        wait_for_retire();
        // Trailing no-ops must not produce any further writes or stores
        repeat (20) @(negedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
